// File: Makefile
# Verilator build and run for the multiply unit testbench

VERILATOR  ?= verilator
TOP        ?= mul_unit_tb
RTL_TOP    ?= mul_unit
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Simulation completed successfully
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS: see $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		source/mul_pkg.sv source/mul_decode.sv source/mul_execute.sv \
		source/mul_result_bank.sv source/mul_unit.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
source/mul_pkg.sv
source/mul_decode.sv
source/mul_execute.sv
source/mul_result_bank.sv
source/mul_unit.sv
testbench/mul_unit_tb.sv

// File: source/mul_decode.sv
////////////////////
// Multiply decode stage
// Operand extension, half select, input register
////////////////////
`default_nettype none

module mul_decode #(
    parameter int NUM_IDS = mul_pkg::DEFAULT_NUM_IDS
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  mul_pkg::mul_issue_t    issue,
    output mul_pkg::mul_operands_t stage1_operands,
    output mul_pkg::mul_ctrl_t     stage1_ctrl
);

    logic                                rs1_signed;    // Extend rs1 with its sign bit
    logic                                rs2_signed;    // Extend rs2 with its sign bit
    logic                                high_next;     // Upper half selected
    mul_pkg::mul_operands_t              operands_next;
    logic [mul_pkg::DEFAULT_NUM_IDS-1:0] one_hot_next;  // Id as one-hot, gated by valid

    ////////////////////
    // Operand extension

    always_comb begin
        // MUL sign choice only touches bits above 31
        rs1_signed = issue.op inside {mul_pkg::MULH_OP, mul_pkg::MULHSU_OP};
        rs2_signed = issue.op inside {mul_pkg::MUL_OP, mul_pkg::MULH_OP};
        high_next = (issue.op != mul_pkg::MUL_OP);

        // 33 bit operands, zero top bit for unsigned
        operands_next.rs1_ext = {issue.rs1[31] & rs1_signed, issue.rs1};
        operands_next.rs2_ext = {issue.rs2[31] & rs2_signed, issue.rs2};
    end

    // Only the first NUM_IDS bits ever set
    always_comb begin
        one_hot_next = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            one_hot_next[i] = issue_valid && (int'(issue.id) == i);
        end
    end

    ////////////////////
    // Stage 1 register

    always_ff @(posedge clk) begin
        stage1_operands <= operands_next; // Loads every cycle, no enable
        stage1_ctrl.high <= high_next;
        stage1_ctrl.id <= issue.id;
        if (reset) begin
            stage1_ctrl.done_one_hot <= '0; // No phantom completion
        end else begin
            stage1_ctrl.done_one_hot <= one_hot_next;
        end
    end

endmodule

`default_nettype wire

// File: source/mul_execute.sv
////////////////////
// Multiply execute stage
// Registered 33x33 signed product
////////////////////
`default_nettype none

module mul_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  mul_pkg::mul_operands_t stage1_operands,
    input  mul_pkg::mul_ctrl_t     stage1_ctrl,
    output logic signed [65:0]     product,
    output mul_pkg::mul_ctrl_t     stage2_ctrl
);

    // Signed views of the extended operands
    logic signed [32:0] rs1_s;
    logic signed [32:0] rs2_s;

    ////////////////////
    // Multiplier

    // Struct fields are unsigned, reinterpret here
    assign rs1_s = stage1_operands.rs1_ext;
    assign rs2_s = stage1_operands.rs2_ext;

    // Input register sits in decode, output register here
    // Maps onto a DSP block with both registers absorbed
    always_ff @(posedge clk) begin
        product <= rs1_s * rs2_s; // Full 66 bit signed result
    end

    ////////////////////
    // Control delay

    // Control follows the product by one stage
    always_ff @(posedge clk) begin
        stage2_ctrl.high <= stage1_ctrl.high;
        stage2_ctrl.id <= stage1_ctrl.id;
        if (reset) begin
            stage2_ctrl.done_one_hot <= '0; // Strobe quiet out of reset
        end else begin
            stage2_ctrl.done_one_hot <= stage1_ctrl.done_one_hot;
        end
    end

endmodule

`default_nettype wire

// File: source/mul_pkg.sv
////////////////////
// Multiply unit shared types
// Opcodes, request struct and pipeline structs
////////////////////
`default_nettype none

package mul_pkg;

    ////////////////////
    // Sizing

    // In-flight instruction ids tracked by default
    localparam int DEFAULT_NUM_IDS = 4;

    // Id field width, covers DEFAULT_NUM_IDS
    localparam int ID_BITS = 2;

    ////////////////////
    // Opcodes

    // Low two bits of funct3, RISC-V M extension order
    typedef enum logic [1:0] {
        MUL_OP    = 2'b00, // Low half, signedness irrelevant
        MULH_OP   = 2'b01, // High half, signed x signed
        MULHSU_OP = 2'b10, // High half, signed x unsigned
        MULHU_OP  = 2'b11  // High half, unsigned x unsigned
    } mul_op_t;

    ////////////////////
    // Structs

    // One request from the core
    typedef struct packed {
        mul_op_t            op;  // Multiply variant
        logic [31:0]        rs1; // First source operand
        logic [31:0]        rs2; // Second source operand
        logic [ID_BITS-1:0] id;  // Instruction id, result bank index
    } mul_issue_t;

    // Control travelling alongside the data
    typedef struct packed {
        logic                       high;         // Upper product half wanted
        logic [ID_BITS-1:0]         id;           // Bank write index
        logic [DEFAULT_NUM_IDS-1:0] done_one_hot; // Zero when no request in stage
    } mul_ctrl_t;

    // Operands widened by one bit so every variant is a signed multiply
    typedef struct packed {
        logic [32:0] rs1_ext;
        logic [32:0] rs2_ext;
    } mul_operands_t;

endpackage

`default_nettype wire

// File: source/mul_result_bank.sv
////////////////////
// Multiply result bank
// Done strobe, id-indexed result storage
////////////////////
`default_nettype none

module mul_result_bank #(
    parameter int NUM_IDS = mul_pkg::DEFAULT_NUM_IDS
) (
    input  logic                        clk,
    input  logic signed [65:0]          product,
    input  mul_pkg::mul_ctrl_t          stage2_ctrl,
    input  logic [mul_pkg::ID_BITS-1:0] rd_id,
    output logic [NUM_IDS-1:0]          done_one_hot,
    output logic [31:0]                 rd_data
);

    logic [31:0] bank [NUM_IDS]; // One result per in-flight id
    logic        write_en;       // Stage 2 holds a live request
    logic [31:0] write_data;     // Selected product half

    ////////////////////
    // Completion

    // Result lands in the bank at the coming edge
    // so the core sees it as done next cycle
    assign done_one_hot = stage2_ctrl.done_one_hot[NUM_IDS-1:0];
    assign write_en = |done_one_hot;

    ////////////////////
    // Half select

    // Bits 65:64 are only sign extension
    always_comb begin
        if (stage2_ctrl.high) begin
            write_data = product[63:32]; // MULH, MULHSU, MULHU
        end else begin
            write_data = product[31:0];  // MUL
        end
    end

    ////////////////////
    // Bank

    // Entry held until the id is issued again
    always_ff @(posedge clk) begin
        if (write_en) begin
            bank[stage2_ctrl.id] <= write_data;
        end
    end

    // Writeback reads by id, no register
    assign rd_data = bank[rd_id];

endmodule

`default_nettype wire

// File: source/mul_unit.sv
////////////////////
// RV32 M-extension multiply unit
////////////////////
`default_nettype none

module mul_unit #(
    parameter int NUM_IDS = mul_pkg::DEFAULT_NUM_IDS // At most DEFAULT_NUM_IDS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        issue_valid,  // One request per cycle
    input  mul_pkg::mul_issue_t         issue,
    input  logic [mul_pkg::ID_BITS-1:0] rd_id,        // Writeback read id
    output logic [NUM_IDS-1:0]          done_one_hot, // Result ready next cycle
    output logic [31:0]                 rd_data
);

    // Stage boundaries
    mul_pkg::mul_operands_t stage1_operands;
    mul_pkg::mul_ctrl_t     stage1_ctrl;
    logic signed [65:0]     product;
    mul_pkg::mul_ctrl_t     stage2_ctrl;

    mul_decode #(.NUM_IDS(NUM_IDS)) u_decode (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .stage1_operands (stage1_operands),
        .stage1_ctrl     (stage1_ctrl)
    );

    mul_execute u_execute (
        .clk             (clk),
        .reset           (reset),
        .stage1_operands (stage1_operands),
        .stage1_ctrl     (stage1_ctrl),
        .product         (product),
        .stage2_ctrl     (stage2_ctrl)
    );

    mul_result_bank #(.NUM_IDS(NUM_IDS)) u_result_bank (
        .clk          (clk),
        .product      (product),
        .stage2_ctrl  (stage2_ctrl),
        .rd_id        (rd_id),
        .done_one_hot (done_one_hot),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

// File: testbench/mul_unit_tb.sv
////////////////////
// Multiply unit testbench
// Directed tests against a reference multiply model
////////////////////
`default_nettype none

module mul_unit_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_IDS    = 4;
    localparam int MAX_CYCLES = 400; // About twice the full test length

    logic                        clk;
    logic                        reset;
    logic                        issue_valid;
    mul_pkg::mul_issue_t         issue;
    logic [mul_pkg::ID_BITS-1:0] rd_id;
    logic [NUM_IDS-1:0]          done_one_hot;
    logic [31:0]                 rd_data;

    int          cycle_count = 0;
    logic [1:0]  next_id = 2'd0; // Rotates through all ids
    logic [31:0] edge_vals [4] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000};
    logic [31:0] mix_a [4] = '{32'hFFFF_FFFB, 32'h0000_0007, 32'h8000_0000, 32'hFFFF_FFFF};
    logic [31:0] mix_b [4] = '{32'h0000_0007, 32'hFFFF_FFFB, 32'h8000_0000, 32'h7FFF_FFFF};

    mul_unit #(.NUM_IDS(NUM_IDS)) dut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rd_id        (rd_id),
        .done_one_hot (done_one_hot),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run exceeded the limit of %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    ////////////////////
    // Reference and helpers

    // 64 bit product of extended operands, half chosen by op
    function automatic logic [31:0] model_mul(mul_pkg::mul_op_t op, logic [31:0] a,
                                              logic [31:0] b);
        logic [63:0] a_wide;
        logic [63:0] b_wide;
        logic [63:0] prod;
        a_wide = {32'h0, a};
        b_wide = {32'h0, b};
        if (op == mul_pkg::MULH_OP || op == mul_pkg::MULHSU_OP) begin
            a_wide = {{32{a[31]}}, a}; // Signed rs1
        end
        if (op == mul_pkg::MULH_OP) begin
            b_wide = {{32{b[31]}}, b}; // Signed rs2
        end
        prod = a_wide * b_wide; // Modulo 2^64 is exact here
        return (op == mul_pkg::MUL_OP) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic drive_issue(input mul_pkg::mul_op_t op, input logic [31:0] a,
                               input logic [31:0] b, input logic [1:0] id);
        issue_valid = 1'b1;
        issue.op = op;
        issue.rs1 = a;
        issue.rs2 = b;
        issue.id = id;
    endtask

    // Read after the write edge, sampled mid low phase
    task automatic read_check(input logic [1:0] id, input logic [31:0] expected);
        @(negedge clk);
        rd_id = id;
        #(CLK_PERIOD/4);
        check_value("rd_data", expected, rd_data);
    endtask

    // One request through the pipe, strobe and result checked
    task automatic run_single(input mul_pkg::mul_op_t op, input logic [31:0] a,
                              input logic [31:0] b);
        logic [1:0] id;
        id = next_id;
        next_id = next_id + 2'd1;
        @(negedge clk);
        drive_issue(op, a, b, id);
        @(negedge clk); // Past issue edge
        issue_valid = 1'b0;
        check_value("done_one_hot", 32'h0, 32'(done_one_hot));
        @(negedge clk); // Strobe cycle
        check_value("done_one_hot", 32'(4'b0001 << id), 32'(done_one_hot));
        read_check(id, model_mul(op, a, b));
        check_value("done_one_hot", 32'h0, 32'(done_one_hot)); // Strobe lasts one cycle
    endtask

    ////////////////////
    // Directed tests

    task automatic idle_after_reset;
        repeat (4) begin
            @(negedge clk);
            check_value("done_one_hot", 32'h0, 32'(done_one_hot));
        end
    endtask

    task automatic low_and_unsigned_ops;
        mul_pkg::mul_op_t op;
        for (int i = 0; i < 4; i++) begin
            run_single(mul_pkg::MUL_OP, edge_vals[i], edge_vals[i]);
            run_single(mul_pkg::MUL_OP, edge_vals[i], edge_vals[3-i]);
            run_single(mul_pkg::MULHU_OP, edge_vals[i], edge_vals[i]);
            run_single(mul_pkg::MULHU_OP, edge_vals[i], edge_vals[3-i]);
        end
        for (int k = 0; k < 16; k++) begin
            op = k[0] ? mul_pkg::MULHU_OP : mul_pkg::MUL_OP; // Alternate ops
            run_single(op, $urandom, $urandom);
        end
    endtask

    task automatic signed_ops;
        mul_pkg::mul_op_t op;
        for (int i = 0; i < 4; i++) begin
            run_single(mul_pkg::MULH_OP, mix_a[i], mix_b[i]);
            run_single(mul_pkg::MULHSU_OP, mix_a[i], mix_b[i]);
        end
        for (int k = 0; k < 8; k++) begin
            op = k[0] ? mul_pkg::MULHSU_OP : mul_pkg::MULH_OP;
            run_single(op, $urandom, $urandom);
        end
    endtask

    task automatic back_to_back_issue;
        mul_pkg::mul_op_t ops [4];
        logic [31:0]      a_vals [4];
        logic [31:0]      b_vals [4];
        ops = '{mul_pkg::MUL_OP, mul_pkg::MULH_OP, mul_pkg::MULHSU_OP, mul_pkg::MULHU_OP};
        for (int k = 0; k < 4; k++) begin
            a_vals[k] = $urandom;
            b_vals[k] = $urandom;
        end
        for (int cyc = 0; cyc < 6; cyc++) begin
            @(negedge clk);
            if (cyc < 4) begin
                drive_issue(ops[cyc], a_vals[cyc], b_vals[cyc], 2'(cyc));
            end else begin
                issue_valid = 1'b0;
            end
            if (cyc >= 2) begin
                check_value("done_one_hot", 32'(4'b0001 << (cyc - 2)), 32'(done_one_hot));
            end else begin
                check_value("done_one_hot", 32'h0, 32'(done_one_hot)); // Pipe still filling
            end
        end
        read_check(2'd2, model_mul(ops[2], a_vals[2], b_vals[2])); // Out of order reads
        read_check(2'd0, model_mul(ops[0], a_vals[0], b_vals[0]));
        read_check(2'd3, model_mul(ops[3], a_vals[3], b_vals[3]));
        read_check(2'd1, model_mul(ops[1], a_vals[1], b_vals[1]));
    endtask

    task automatic retention_and_reuse;
        logic [31:0] first_val;
        logic [31:0] second_val;
        first_val = model_mul(mul_pkg::MULH_OP, 32'h1234_5678, 32'hFEDC_BA98);
        second_val = model_mul(mul_pkg::MULHU_OP, 32'hFFFF_0000, 32'h0001_0001);
        next_id = 2'd1;
        run_single(mul_pkg::MULH_OP, 32'h1234_5678, 32'hFEDC_BA98); // Id 1
        run_single(mul_pkg::MUL_OP, 32'h0000_0003, 32'hFFFF_FFFE);
        run_single(mul_pkg::MULHU_OP, 32'hDEAD_BEEF, 32'h0BAD_F00D);
        run_single(mul_pkg::MULHSU_OP, 32'h8765_4321, 32'h9ABC_DEF0);
        read_check(2'd1, first_val); // Untouched by ids 2, 3, 0
        @(negedge clk);
        drive_issue(mul_pkg::MULHU_OP, 32'hFFFF_0000, 32'h0001_0001, 2'd1);
        rd_id = 2'd1;
        @(negedge clk);
        issue_valid = 1'b0;
        @(negedge clk); // Before the new write edge
        check_value("done_one_hot", 32'h2, 32'(done_one_hot));
        check_value("rd_data", first_val, rd_data);
        read_check(2'd1, second_val);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        void'($urandom(98));
        reset = 1'b1;
        issue_valid = 1'b1; // Request held during reset must never complete
        issue = '0;
        rd_id = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        issue_valid = 1'b0;
        idle_after_reset();
        low_and_unsigned_ops();
        signed_ops();
        back_to_back_issue();
        retention_and_reuse();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
